/* dv/rename_checker.sv */
`timescale 1ns/1ps

module rename_checker import rename_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        req_valid,
    input logic        req_ready,
    input logic        rsp_valid,
    input rename_rsp_t rsp,
    input logic        ckpt_full
);

    rename_rsp_t exp_q [$];           // responses still owed, oldest first
    logic        page_chk_q [$];      // page only matters for checkpointing requests
    int          error_count = 0;
    int          rsp_count   = 0;
    logic        accepted_q  = 1'b0;  // a request transferred on the previous edge
    logic        stall_on    = 1'b0;  // the request being held must not be taken

    task automatic report_failure(input string msg);
        $display("%0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s expected %0d got %0d", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic expect_rsp(input int src1, input int src2, input int rd, input int prev,
                              input int page, input logic check_page);
        rename_rsp_t e;
        e.src1_tag  = TAG_W'(src1);
        e.src2_tag  = TAG_W'(src2);
        e.rd_tag    = TAG_W'(rd);
        e.prev_tag  = TAG_W'(prev);
        e.ckpt_page = PAGE_W'(page);
        exp_q.push_back(e);
        page_chk_q.push_back(check_page);
    endtask

    task automatic compare_rsp();
        rename_rsp_t e;
        logic        chk;
        e   = exp_q.pop_front();
        chk = page_chk_q.pop_front();
        rsp_count++;
        compare_field("src1_tag", e.src1_tag, rsp.src1_tag);
        compare_field("src2_tag", e.src2_tag, rsp.src2_tag);
        compare_field("rd_tag", e.rd_tag, rsp.rd_tag);
        compare_field("prev_tag", e.prev_tag, rsp.prev_tag);
        if (chk) begin
            compare_field("ckpt_page", e.ckpt_page, rsp.ckpt_page);
        end
    endtask

    task automatic set_stall(input logic on);
        stall_on = on;
    endtask

    task automatic check_full(input logic expected);
        compare_field("ckpt_full", expected, ckpt_full);
    endtask

    // all DUT outputs come from flops or from inputs that settled on the falling edge
    always @(posedge clk) begin
        if (reset) begin
            accepted_q <= 1'b0;
        end else begin
            if (accepted_q && !rsp_valid) begin
                report_failure("an accepted request got no response on the next cycle");
            end
            if (rsp_valid && exp_q.size() == 0) begin
                report_failure("a response arrived with no expected response waiting");
            end else if (rsp_valid) begin
                compare_rsp();
            end
            if (stall_on && req_valid && req_ready) begin
                report_failure("a request was accepted while it should have stalled");
            end
            accepted_q <= req_valid && req_ready;
        end
    end

    task automatic finish_report(output int errors);
        if (exp_q.size() != 0) begin
            report_failure($sformatf("%0d expected responses never arrived", exp_q.size()));
        end
        $display("rename checker: %0d responses compared, %0d errors", rsp_count, error_count);
        errors = error_count;
    endtask

endmodule

/* dv/rename_tb.sv */
`timescale 1ns/1ps

module rename_tb import rename_pkg::*; ();

    logic             clk;
    logic             reset;
    logic             req_valid;
    rename_req_t      req;
    logic             req_ready;
    logic             rsp_valid;
    rename_rsp_t      rsp;
    logic             resolve_valid;
    recover_t         resolve;
    logic             free_valid;
    logic [TAG_W-1:0] free_tag;
    logic             ckpt_full;
    int               cycle_count = 0;
    int               cycle_limit = 0;  // set once the trace has been counted
    int               timeout_errors;

    tb_clock u_clock (.clk(clk), .reset(reset));

    rename_unit u_dut (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .resolve_valid (resolve_valid),
        .resolve       (resolve),
        .free_valid    (free_valid),
        .free_tag      (free_tag),
        .ckpt_full     (ckpt_full)
    );

    rename_checker u_checker (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .ckpt_full (ckpt_full)
    );

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            u_checker.report_failure($sformatf("timeout after %0d cycles with the trace unfinished",
                                               cycle_count));
            u_checker.finish_report(timeout_errors);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic skip_line(input int fd);
        int c;
        c = $fgetc(fd);
        while (c != -1 && c != "\n") begin
            c = $fgetc(fd);
        end
    endtask

    // next operation letter, or 0 at the end of the file
    task automatic read_op(input int fd, output int op);
        int c;
        op = 0;
        c  = $fgetc(fd);
        while (c != -1 && op == 0) begin
            if (c == "#") begin
                skip_line(fd);  // comments run to the end of the line
                c = $fgetc(fd);
            end else if (c == " " || c == "\t" || c == "\n" || c == "\r") begin
                c = $fgetc(fd);
            end else begin
                op = c;
            end
        end
    endtask

    task automatic set_req(input int opcode, input int rs1, input int rs2, input int rd,
                           input int ckpt);
        req.opcode    = 7'(opcode);
        req.rs1       = LOG_W'(rs1);
        req.rs2       = LOG_W'(rs2);
        req.rd        = LOG_W'(rd);
        req.take_ckpt = (ckpt != 0);
        req_valid     = 1'b1;
    endtask

    task automatic rename_one(input int opcode, input int rs1, input int rs2, input int rd,
                              input int ckpt);
        set_req(opcode, rs1, rs2, rd, ckpt);
        do begin
            @(posedge clk);
        end while (!req_ready);  // req stays put until the DUT takes it
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    // renames one register count times while the free list hands out ascending tags
    task automatic bulk_rename(input int opcode, input int count, input int arch,
                               input int first_tag, input int prev_tag);
        int cur;
        cur = prev_tag;
        for (int k = 0; k < count; k++) begin
            u_checker.expect_rsp(cur, cur, first_tag + k, cur, 0, 1'b0);
            rename_one(opcode, arch, arch, arch, 0);
            cur = first_tag + k;
        end
    endtask

    task automatic send_resolve(input logic mispredict, input int page);
        resolve_valid      = 1'b1;
        resolve.mispredict = mispredict;
        resolve.correct    = !mispredict;
        resolve.page       = PAGE_W'(page);
        @(negedge clk);
        resolve_valid = 1'b0;
    endtask

    initial begin
        int fd;
        int op;
        int code;
        int n_ops;
        int errors;
        int f [10];
        req_valid     = 1'b0;
        req           = '0;
        resolve_valid = 1'b0;
        resolve       = '0;
        free_valid    = 1'b0;
        free_tag      = '0;
        n_ops         = 0;
        fd = $fopen("dv/rename_trace.txt", "r");
        if (fd == 0) begin
            u_checker.report_failure("could not open dv/rename_trace.txt");
        end else begin
            read_op(fd, op);
            while (op != 0) begin
                n_ops++;
                skip_line(fd);
                read_op(fd, op);
            end
            $fclose(fd);
            cycle_limit = 20 * n_ops + 100;
            fd = $fopen("dv/rename_trace.txt", "r");
            do begin
                @(negedge clk);
            end while (reset);
            read_op(fd, op);
            while (op != 0) begin
                case (op)
                    "R": begin
                        code = $fscanf(fd, "%h %d %d %d %d %d %d %d %d %d", f[0], f[1], f[2],
                                       f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
                        if (code != 10) begin
                            u_checker.report_failure("malformed rename line in the trace");
                        end else begin
                            u_checker.expect_rsp(f[5], f[6], f[7], f[8], f[9], f[4] != 0);
                            rename_one(f[0], f[1], f[2], f[3], f[4]);
                        end
                    end
                    "N": begin
                        code = $fscanf(fd, "%h %d %d %d %d", f[0], f[1], f[2], f[3], f[4]);
                        if (code != 5) begin
                            u_checker.report_failure("malformed bulk rename line in the trace");
                        end else begin
                            bulk_rename(f[0], f[1], f[2], f[3], f[4]);
                        end
                    end
                    "S": begin
                        code = $fscanf(fd, "%h %d %d %d %d %d", f[0], f[1], f[2], f[3], f[4],
                                       f[5]);
                        if (code != 6) begin
                            u_checker.report_failure("malformed stall line in the trace");
                        end else begin
                            set_req(f[0], f[1], f[2], f[3], f[4]);
                            u_checker.set_stall(1'b1);
                            repeat (f[5]) @(negedge clk);
                            req_valid = 1'b0;  // the held request is withdrawn untaken
                            u_checker.set_stall(1'b0);
                        end
                    end
                    "F": begin
                        code = $fscanf(fd, "%d", f[0]);
                        if (code != 1) begin
                            u_checker.report_failure("malformed free line in the trace");
                        end else begin
                            free_valid = 1'b1;
                            free_tag   = TAG_W'(f[0]);
                            @(negedge clk);
                            free_valid = 1'b0;
                        end
                    end
                    "M": begin
                        code = $fscanf(fd, "%d", f[0]);
                        if (code != 1) begin
                            u_checker.report_failure("malformed mispredict line in the trace");
                        end else begin
                            send_resolve(1'b1, f[0]);
                        end
                    end
                    "K": send_resolve(1'b0, 0);
                    "C": begin
                        code = $fscanf(fd, "%d", f[0]);
                        if (code != 1) begin
                            u_checker.report_failure("malformed full check line in the trace");
                        end else begin
                            u_checker.check_full(f[0] != 0);
                        end
                    end
                    "W": begin
                        code = $fscanf(fd, "%d", f[0]);
                        if (code != 1) begin
                            u_checker.report_failure("malformed wait line in the trace");
                        end else begin
                            repeat (f[0]) @(negedge clk);
                        end
                    end
                    default: u_checker.report_failure("unknown operation in the trace");
                endcase
                read_op(fd, op);
            end
            $fclose(fd);
            repeat (3) @(negedge clk);  // let the last response drain
        end
        u_checker.finish_report(errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* dv/rename_trace.txt */
# R opcode(hex) rs1 rs2 rd ckpt, then expected src1 src2 rd prev page (page checked with ckpt)
# N opcode count reg first prev | S opcode rs1 rs2 rd ckpt cycles | F tag | M page | K | C full | W n
# identity map after reset, first free tag is 32
R 33 3 4 5 0   3 4 32 5 0
R 33 5 6 7 0   32 6 33 7 0
# sentinels by opcode class
R 13 5 9 8 0   32 254 34 8 0
R 37 1 2 9 0   254 254 35 9 0
R 63 7 8 0 0   33 34 255 255 0
R 23 5 9 0 0   32 35 255 255 0
R 33 1 2 0 0   1 2 255 255 0
R 33 5 5 5 0   32 32 36 32 0
# checkpoint on page 0, two younger renames, then a mispredict
R 63 5 7 0 1   36 33 255 255 0
R 33 1 1 5 0   1 1 37 36 0
R 13 5 0 7 0   37 254 38 33 0
M 0
R 33 5 7 10 0  36 33 37 10 0
# fill all eight pages, the ninth waits for a correct resolve
R 63 1 2 0 1   1 2 255 255 0
R 6f 0 0 1 1   254 254 38 1 1
R 63 1 2 0 1   38 2 255 255 2
R 63 1 2 0 1   38 2 255 255 3
R 63 1 2 0 1   38 2 255 255 4
R 63 1 2 0 1   38 2 255 255 5
R 63 1 2 0 1   38 2 255 255 6
R 63 1 2 0 1   38 2 255 255 7
C 1
S 63 1 2 0 1 3
K
C 0
R 63 1 2 0 1   38 2 255 255 0
M 1
C 0
# drain the free list, then refill it through the commit port
N 33 89 11 39 11
S 33 11 11 11 0 3
R 63 11 11 0 0 127 127 255 255 0
F 5
F 36
F 7
R 33 11 0 12 0 127 0 5 12 0
R 33 12 12 13 0 5 5 36 13 0
R 13 13 0 14 0 36 254 7 14 0
S 33 1 1 1 0 2
W 2

/* dv/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);  // release away from the edge the DUT samples on
        reset = 1'b0;
    end

endmodule

/* rename_unit.f */
verilog/rename_pkg.sv
verilog/rename_ctrl.sv
verilog/checkpoint_pool.sv
verilog/rename_map_table.sv
verilog/free_list.sv
verilog/rename_unit.sv
dv/tb_clock.sv
dv/rename_checker.sv
dv/rename_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the rename stage testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal --top-module rename_tb \
    -f rename_unit.f -Mdir "$OBJ" -o rename_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/rename_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL TESTS PASSED$" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $LOG"
exit 1

/* verilog/checkpoint_pool.sv */
`timescale 1ns/1ps

module checkpoint_pool import rename_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  rename_cmd_t       cmd,
    input  logic              resolve_valid,
    input  recover_t          resolve,
    output logic [PAGE_W-1:0] alloc_page,
    output logic              pool_full
);

    logic [PAGE_W-1:0] oldest_q;  // page of the oldest unresolved branch
    logic [PAGE_W-1:0] next_q;    // page the next checkpoint lands in
    logic [PAGE_W:0]   count_q;   // 0 to NUM_PAGES pages held
    logic [PAGE_W-1:0] keep_span; // pages older than the mispredicted one
    logic              release_oldest;
    logic              squash;

    assign squash         = resolve_valid && resolve.mispredict;
    assign release_oldest = resolve_valid && resolve.correct && (count_q != '0);
    assign keep_span      = resolve.page - oldest_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            oldest_q <= '0;
            next_q   <= '0;
            count_q  <= '0;
        end else if (squash) begin
            // the faulting page and everything younger go back to the pool
            next_q  <= resolve.page;
            count_q <= {1'b0, keep_span};
        end else begin
            if (cmd.save_ckpt) next_q <= next_q + 1'b1;
            if (release_oldest) oldest_q <= oldest_q + 1'b1;
            case ({cmd.save_ckpt, release_oldest})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign alloc_page = next_q;
    assign pool_full  = (count_q == (PAGE_W+1)'(NUM_PAGES));

endmodule

/* verilog/free_list.sv */
`timescale 1ns/1ps

module free_list import rename_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  rename_cmd_t       cmd,
    input  logic [PAGE_W-1:0] alloc_page,
    input  logic              restore,
    input  logic [PAGE_W-1:0] restore_page,
    input  logic              free_valid,
    input  logic [TAG_W-1:0]  free_tag,
    output logic [TAG_W-1:0]  head_tag,
    output logic              empty
);

    logic [TAG_W-1:0]      slot_q [FREE_DEPTH];
    logic [FREE_IDX_W-1:0] head_q;
    logic [FREE_IDX_W-1:0] tail_q;
    logic                  head_wrap_q;  // wrap bits tell full from empty
    logic                  tail_wrap_q;
    logic [FREE_IDX_W-1:0] saved_idx_q [NUM_PAGES];
    logic                  saved_wrap_q [NUM_PAGES];
    logic [FREE_IDX_W-1:0] head_nxt;
    logic                  head_wrap_nxt;

    localparam logic [FREE_IDX_W-1:0] LAST_IDX = FREE_IDX_W'(FREE_DEPTH - 1);

    // head after this cycle's pop, also what a checkpoint records
    always_comb begin
        head_nxt      = head_q;
        head_wrap_nxt = head_wrap_q;
        if (cmd.write_rd) begin
            head_nxt      = (head_q == LAST_IDX) ? '0 : head_q + 1'b1;
            head_wrap_nxt = head_wrap_q ^ (head_q == LAST_IDX);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head_q      <= '0;
            head_wrap_q <= 1'b0;
            tail_q      <= '0;
            tail_wrap_q <= 1'b1;  // starts full
        end else begin
            if (restore) begin
                head_q      <= saved_idx_q[restore_page];
                head_wrap_q <= saved_wrap_q[restore_page];
            end else begin
                head_q      <= head_nxt;
                head_wrap_q <= head_wrap_nxt;
            end
            if (free_valid) begin
                tail_q      <= (tail_q == LAST_IDX) ? '0 : tail_q + 1'b1;
                tail_wrap_q <= tail_wrap_q ^ (tail_q == LAST_IDX);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < FREE_DEPTH; i++) begin
                slot_q[i] <= TAG_W'(NUM_LOGICAL + i);  // tags above the identity map
            end
        end else if (free_valid) begin
            slot_q[tail_q] <= free_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.save_ckpt) begin
            saved_idx_q[alloc_page]  <= head_nxt;
            saved_wrap_q[alloc_page] <= head_wrap_nxt;
        end
    end

    assign head_tag = slot_q[head_q];
    assign empty    = (head_q == tail_q) && (head_wrap_q == tail_wrap_q);

endmodule

/* verilog/rename_ctrl.sv */
`timescale 1ns/1ps

module rename_ctrl import rename_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              req_valid,
    input  rename_req_t       req,
    output logic              req_ready,
    input  logic              resolve_valid,
    input  recover_t          resolve,
    input  logic              empty,
    input  logic              pool_full,
    output rename_cmd_t       cmd,
    output logic              restore,
    output logic [PAGE_W-1:0] restore_page,
    output logic              rsp_valid
);

    typedef enum logic {
        RUN     = 1'b0,
        RECOVER = 1'b1
    } state_t;

    state_t state_q;
    logic   no_src;    // lui, auipc, jal
    logic   one_src;   // jalr, load, immediate alu
    logic   no_rd;     // branch, store, nop
    logic   needs_rd;

    always_comb begin
        no_src  = (req.opcode == OPC_LUI) || (req.opcode == OPC_AUIPC) ||
                  (req.opcode == OPC_JAL);
        one_src = (req.opcode == OPC_JALR) || (req.opcode == OPC_LOAD) ||
                  (req.opcode == OPC_IMM);
        no_rd   = (req.opcode == OPC_BRANCH) || (req.opcode == OPC_STORE) ||
                  (req.opcode == OPC_NOP);
    end

    assign needs_rd = !no_rd && (req.rd != '0);  // x0 is never renamed

    // hold off while a resolve is in flight or a needed resource is exhausted
    assign req_ready = (state_q == RUN) && !resolve_valid &&
                       (!needs_rd || !empty) && (!req.take_ckpt || !pool_full);

    always_comb begin
        cmd.fire      = req_valid && req_ready;
        cmd.use_rs1   = !no_src;
        cmd.use_rs2   = !no_src && !one_src;
        cmd.write_rd  = cmd.fire && needs_rd;
        cmd.save_ckpt = cmd.fire && req.take_ckpt;
        cmd.rs1       = req.rs1;
        cmd.rs2       = req.rs2;
        cmd.rd        = req.rd;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= RUN;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= cmd.fire;  // response follows acceptance by one cycle
            case (state_q)
                RUN: if (resolve_valid && resolve.mispredict) state_q <= RECOVER;
                default: state_q <= RUN;  // recovery always takes a single cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (resolve_valid && resolve.mispredict) restore_page <= resolve.page;
    end

    assign restore = (state_q == RECOVER);

endmodule

/* verilog/rename_map_table.sv */
`timescale 1ns/1ps

module rename_map_table import rename_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  rename_cmd_t       cmd,
    input  logic [TAG_W-1:0]  head_tag,
    input  logic [PAGE_W-1:0] alloc_page,
    input  logic              restore,
    input  logic [PAGE_W-1:0] restore_page,
    output rename_rsp_t       rsp
);

    // speculative alias table, one physical tag per architectural register
    logic [TAG_W-1:0] map_q [NUM_LOGICAL];

    // checkpoint pages, each a full copy of the table
    logic [TAG_W-1:0] page_q [NUM_PAGES][NUM_LOGICAL];

    // table as it will look once this cycle's rd remap lands
    logic [TAG_W-1:0] map_nxt [NUM_LOGICAL];

    // lookups against the table before the remap
    logic [TAG_W-1:0] src1_tag;
    logic [TAG_W-1:0] src2_tag;
    logic [TAG_W-1:0] prev_tag;

    always_comb begin
        map_nxt = map_q;
        if (cmd.write_rd) begin
            map_nxt[cmd.rd] = head_tag;  // rd takes the tag at the free-list head
        end
    end

    always_comb begin
        if (cmd.use_rs1) begin
            src1_tag = map_q[cmd.rs1];
        end else begin
            src1_tag = TAG_UNUSED_SRC;
        end

        if (cmd.use_rs2) begin
            src2_tag = map_q[cmd.rs2];
        end else begin
            src2_tag = TAG_UNUSED_SRC;
        end

        if (cmd.write_rd) begin
            prev_tag = map_q[cmd.rd];  // freed once this instruction commits
        end else begin
            prev_tag = TAG_NO_RD;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_LOGICAL; i++) begin
                map_q[i] <= TAG_W'(i);  // identity mapping out of reset
            end
        end else if (restore) begin
            map_q <= page_q[restore_page];  // roll back to the branch's view
        end else begin
            map_q <= map_nxt;
        end
    end

    // a branch that writes rd (jal, jalr) keeps its own remap in the page
    always_ff @(posedge clk) begin
        if (cmd.save_ckpt) begin
            page_q[alloc_page] <= map_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.fire) begin
            rsp.src1_tag  <= src1_tag;
            rsp.src2_tag  <= src2_tag;
            rsp.rd_tag    <= cmd.write_rd ? head_tag : TAG_NO_RD;
            rsp.prev_tag  <= prev_tag;
            rsp.ckpt_page <= alloc_page;  // only meaningful with take_ckpt set
        end
    end

endmodule

/* verilog/rename_pkg.sv */
package rename_pkg;

    // register file geometry
    localparam int NUM_LOGICAL = 32;
    localparam int LOG_W       = 5;
    localparam int NUM_PHYS    = 128;
    localparam int TAG_W       = 8;   // top bit only ever set by the sentinels
    localparam int NUM_PAGES   = 8;
    localparam int PAGE_W      = 3;

    // free list geometry, the first NUM_LOGICAL tags start out mapped
    localparam int FREE_DEPTH  = NUM_PHYS - NUM_LOGICAL;
    localparam int FREE_IDX_W  = 7;

    // sentinel tags reported on the response port
    localparam logic [TAG_W-1:0] TAG_UNUSED_SRC = 8'd254;
    localparam logic [TAG_W-1:0] TAG_NO_RD      = 8'd255;

    // RV32I major opcodes that the stage tells apart
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_NOP    = 7'b0000000;

    typedef struct packed {
        logic [6:0]       opcode;
        logic [LOG_W-1:0] rs1;
        logic [LOG_W-1:0] rs2;
        logic [LOG_W-1:0] rd;
        logic             take_ckpt;  // branch or jump that may need recovery
    } rename_req_t;

    typedef struct packed {
        logic             fire;       // request transfers this cycle
        logic             use_rs1;
        logic             use_rs2;
        logic             write_rd;   // already qualified by fire
        logic             save_ckpt;  // already qualified by fire
        logic [LOG_W-1:0] rs1;
        logic [LOG_W-1:0] rs2;
        logic [LOG_W-1:0] rd;
    } rename_cmd_t;

    typedef struct packed {
        logic [TAG_W-1:0]  src1_tag;
        logic [TAG_W-1:0]  src2_tag;
        logic [TAG_W-1:0]  rd_tag;
        logic [TAG_W-1:0]  prev_tag;
        logic [PAGE_W-1:0] ckpt_page;
    } rename_rsp_t;

    typedef struct packed {
        logic              mispredict;
        logic              correct;
        logic [PAGE_W-1:0] page;
    } recover_t;

endpackage

/* verilog/rename_unit.sv */
`timescale 1ns/1ps

module rename_unit import rename_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             req_valid,
    input  rename_req_t      req,
    output logic             req_ready,
    output logic             rsp_valid,
    output rename_rsp_t      rsp,
    input  logic             resolve_valid,
    input  recover_t         resolve,
    input  logic             free_valid,
    input  logic [TAG_W-1:0] free_tag,
    output logic             ckpt_full
);

    rename_cmd_t       cmd;
    logic              restore;
    logic [PAGE_W-1:0] restore_page;
    logic [PAGE_W-1:0] alloc_page;
    logic [TAG_W-1:0]  head_tag;
    logic              empty;

    rename_ctrl u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .resolve_valid (resolve_valid),
        .resolve       (resolve),
        .empty         (empty),
        .pool_full     (ckpt_full),
        .cmd           (cmd),
        .restore       (restore),
        .restore_page  (restore_page),
        .rsp_valid     (rsp_valid)
    );

    checkpoint_pool u_pool (
        .clk           (clk),
        .reset         (reset),
        .cmd           (cmd),
        .resolve_valid (resolve_valid),
        .resolve       (resolve),
        .alloc_page    (alloc_page),
        .pool_full     (ckpt_full)   // pool state is exported as is
    );

    rename_map_table u_map (
        .clk          (clk),
        .reset        (reset),
        .cmd          (cmd),
        .head_tag     (head_tag),
        .alloc_page   (alloc_page),
        .restore      (restore),
        .restore_page (restore_page),
        .rsp          (rsp)
    );

    free_list u_free (
        .clk          (clk),
        .reset        (reset),
        .cmd          (cmd),
        .alloc_page   (alloc_page),
        .restore      (restore),
        .restore_page (restore_page),
        .free_valid   (free_valid),
        .free_tag     (free_tag),
        .head_tag     (head_tag),
        .empty        (empty)
    );

endmodule
